/* design/matvec_defs.svh */
`ifndef MATVEC_DEFS_SVH
`define MATVEC_DEFS_SVH

// the matrix is MATVEC_N by MATVEC_N and the vector has MATVEC_N entries
`define MATVEC_N 8

// width of every matrix and vector element on the input stream
`define MATVEC_IN_W 14

// a full 14x14 signed product fits exactly in 28 bits
// the accumulator keeps the same width and saturates instead of growing
`define MATVEC_ACC_W 28

// register stages inside the multiplier, at least 1
`define MATVEC_MULT_STAGES 3

`endif

/* design/matvec_pkg.sv */
`include "matvec_defs.svh"

package matvec_pkg;

    // one signed matrix or vector element
    typedef logic signed [`MATVEC_IN_W-1:0] elem_t;

    // signed product and running row sum
    typedef logic signed [`MATVEC_ACC_W-1:0] acc_t;

    // matrix memory is row major, so the address is {row, column}
    typedef logic [$clog2(`MATVEC_N*`MATVEC_N)-1:0] w_addr_t;

    // vector memory address, also the column index
    typedef logic [$clog2(`MATVEC_N)-1:0] x_addr_t;

endpackage

/* design/coeff_memory.sv */
`timescale 1ns/1ps

module coeff_memory #(
    parameter int DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  matvec_pkg::elem_t        data_in,
    output matvec_pkg::elem_t        data_out
);

    matvec_pkg::elem_t mem [DEPTH];

    // read is registered and returns the old value when a write hits the same address
    always_ff @(posedge clk) begin
        data_out <= mem[addr];
        if (wr_en) begin
            mem[addr] <= data_in;
        end
    end

endmodule

/* design/pipe_multiplier.sv */
`timescale 1ns/1ps

module pipe_multiplier #(
    parameter int STAGES = 3
) (
    input  logic              clk,
    input  matvec_pkg::elem_t a,
    input  matvec_pkg::elem_t b,
    output matvec_pkg::acc_t  product
);

    matvec_pkg::acc_t full_product;
    matvec_pkg::acc_t stage_q [STAGES];

    // both operands are sign extended to the product width, so nothing is lost
    assign full_product = matvec_pkg::acc_t'(a) * matvec_pkg::acc_t'(b);

    // the product moves through STAGES registers and the datapath flags mark the real ones
    always_ff @(posedge clk) begin
        stage_q[0] <= full_product;
        for (int i = 1; i < STAGES; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    assign product = stage_q[STAGES-1];

endmodule

/* design/mac_datapath.sv */
`timescale 1ns/1ps
`include "matvec_defs.svh"

module mac_datapath (
    input  logic                clk,
    input  logic                reset,
    input  matvec_pkg::elem_t   input_data,
    input  logic                w_wr_en,
    input  logic                x_wr_en,
    input  matvec_pkg::w_addr_t w_addr,
    input  matvec_pkg::x_addr_t x_addr,
    input  logic                rd_en,
    input  logic                row_first,
    input  logic                row_last,
    output logic                output_valid,
    input  logic                output_ready,
    output matvec_pkg::acc_t    output_data,
    output logic                result_taken
);

    // one cycle for the memory read plus the multiplier stages
    localparam int LAT = 1 + `MATVEC_MULT_STAGES;

    localparam matvec_pkg::acc_t ACC_MAX = {1'b0, {(`MATVEC_ACC_W-1){1'b1}}};
    localparam matvec_pkg::acc_t ACC_MIN = {1'b1, {(`MATVEC_ACC_W-1){1'b0}}};

    matvec_pkg::elem_t w_q;
    matvec_pkg::elem_t x_q;
    matvec_pkg::acc_t  product;
    matvec_pkg::acc_t  acc;
    matvec_pkg::acc_t  acc_next;
    logic [LAT-1:0]    vld_q;
    logic [LAT-1:0]    first_q;
    logic [LAT-1:0]    last_q;

    // add one bit of headroom and clamp when the sign bits disagree
    function automatic matvec_pkg::acc_t sat_add(input matvec_pkg::acc_t x,
                                                 input matvec_pkg::acc_t y);
        logic signed [`MATVEC_ACC_W:0] wide;
        wide = {x[`MATVEC_ACC_W-1], x} + {y[`MATVEC_ACC_W-1], y};
        if (wide[`MATVEC_ACC_W] != wide[`MATVEC_ACC_W-1]) begin
            return wide[`MATVEC_ACC_W] ? ACC_MIN : ACC_MAX;
        end
        return wide[`MATVEC_ACC_W-1:0];
    endfunction

    coeff_memory #(.DEPTH(`MATVEC_N * `MATVEC_N)) u_w_mem (
        .clk      (clk),
        .wr_en    (w_wr_en),
        .addr     (w_addr),
        .data_in  (input_data),
        .data_out (w_q)
    );

    coeff_memory #(.DEPTH(`MATVEC_N)) u_x_mem (
        .clk      (clk),
        .wr_en    (x_wr_en),
        .addr     (x_addr),
        .data_in  (input_data),
        .data_out (x_q)
    );

    pipe_multiplier #(.STAGES(`MATVEC_MULT_STAGES)) u_mult (
        .clk     (clk),
        .a       (w_q),
        .b       (x_q),
        .product (product)
    );

    // flags ride along with each read so the top bit lines up with its product
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q   <= '0;
            first_q <= '0;
            last_q  <= '0;
        end else begin
            vld_q   <= {vld_q[LAT-2:0], rd_en};
            first_q <= {first_q[LAT-2:0], row_first};
            last_q  <= {last_q[LAT-2:0], row_last};
        end
    end

    assign acc_next = first_q[LAT-1] ? product : sat_add(acc, product);

    always_ff @(posedge clk) begin
        if (vld_q[LAT-1]) begin
            acc <= acc_next;
        end
        if (vld_q[LAT-1] && last_q[LAT-1]) begin
            output_data <= acc_next;   // held until the next row finishes
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            output_valid <= 1'b0;
        end else if (vld_q[LAT-1] && last_q[LAT-1]) begin
            output_valid <= 1'b1;
        end else if (result_taken) begin
            output_valid <= 1'b0;
        end
    end

    // the control never issues a new row before this pulse, so load and clear never meet
    assign result_taken = output_valid && output_ready;

endmodule

/* design/matvec_control.sv */
`timescale 1ns/1ps
`include "matvec_defs.svh"

module matvec_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                input_valid,
    input  logic                new_matrix,
    output logic                input_ready,
    input  logic                result_taken,
    output logic                w_wr_en,
    output logic                x_wr_en,
    output matvec_pkg::w_addr_t w_addr,
    output matvec_pkg::x_addr_t x_addr,
    output logic                rd_en,
    output logic                row_first,
    output logic                row_last
);

    localparam matvec_pkg::x_addr_t LAST_IDX  = matvec_pkg::x_addr_t'(`MATVEC_N - 1);
    localparam matvec_pkg::w_addr_t LAST_ELEM =
        matvec_pkg::w_addr_t'(`MATVEC_N * `MATVEC_N - 1);

    // ST_LOAD_W doubles as idle, it waits for the first word of the next job
    typedef enum logic [1:0] {
        ST_LOAD_W,
        ST_LOAD_X,
        ST_ISSUE,
        ST_WAIT
    } state_t;

    state_t              state;
    matvec_pkg::w_addr_t elem_cnt;     // matrix words written so far
    matvec_pkg::x_addr_t col;          // vector load index and compute column
    matvec_pkg::x_addr_t row;          // row being computed
    logic                accept;
    logic                matrix_word;

    always_comb begin
        input_ready = (state == ST_LOAD_W) || (state == ST_LOAD_X);
        accept      = input_valid && input_ready;

        // new_matrix only counts with the first word, later words follow the counter
        matrix_word = (state == ST_LOAD_W) && ((elem_cnt != '0) || new_matrix);

        // writes happen on the same edge that accepts the word
        w_wr_en = accept && matrix_word;
        x_wr_en = accept && !matrix_word;

        // one port per memory, shared between loading and reading
        w_addr = (state == ST_LOAD_W) ? elem_cnt : {row, col};
        x_addr = col;

        rd_en     = (state == ST_ISSUE);
        row_first = rd_en && (col == '0);
        row_last  = rd_en && (col == LAST_IDX);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_LOAD_W;
            elem_cnt <= '0;
            col      <= '0;
            row      <= '0;
        end else begin
            case (state)
                ST_LOAD_W: begin
                    if (accept) begin
                        if (matrix_word) begin
                            elem_cnt <= elem_cnt + 1'b1;   // wraps to 0 after the last word
                            if (elem_cnt == LAST_ELEM) begin
                                state <= ST_LOAD_X;
                            end
                        end else begin
                            // matrix reuse, this word was already vector entry 0
                            col   <= col + 1'b1;
                            state <= ST_LOAD_X;
                        end
                    end
                end

                ST_LOAD_X: begin
                    if (accept) begin
                        col <= col + 1'b1;
                        if (col == LAST_IDX) begin
                            state <= ST_ISSUE;   // input_ready drops from the next cycle
                        end
                    end
                end

                ST_ISSUE: begin
                    // one read per cycle across the row, col wraps back to 0 at the end
                    col <= col + 1'b1;
                    if (col == LAST_IDX) begin
                        state <= ST_WAIT;
                    end
                end

                ST_WAIT: begin
                    // hold here while the consumer stalls the output
                    if (result_taken) begin
                        row <= row + 1'b1;
                        if (row == LAST_IDX) begin
                            state <= ST_LOAD_W;   // job done, take new input
                        end else begin
                            state <= ST_ISSUE;
                        end
                    end
                end

                default: begin
                    state <= ST_LOAD_W;
                end
            endcase
        end
    end

endmodule

/* design/matvec_top.sv */
`timescale 1ns/1ps

module matvec_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               input_valid,
    output logic               input_ready,
    input  matvec_pkg::elem_t  input_data,
    input  logic               new_matrix,
    output logic               output_valid,
    input  logic               output_ready,
    output matvec_pkg::acc_t   output_data
);

    logic                w_wr_en;
    logic                x_wr_en;
    matvec_pkg::w_addr_t w_addr;
    matvec_pkg::x_addr_t x_addr;
    logic                rd_en;
    logic                row_first;
    logic                row_last;
    logic                result_taken;   // output handshake seen by the sequencer

    matvec_control u_control (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .new_matrix   (new_matrix),
        .input_ready  (input_ready),
        .result_taken (result_taken),
        .w_wr_en      (w_wr_en),
        .x_wr_en      (x_wr_en),
        .w_addr       (w_addr),
        .x_addr       (x_addr),
        .rd_en        (rd_en),
        .row_first    (row_first),
        .row_last     (row_last)
    );

    mac_datapath u_datapath (
        .clk          (clk),
        .reset        (reset),
        .input_data   (input_data),
        .w_wr_en      (w_wr_en),
        .x_wr_en      (x_wr_en),
        .w_addr       (w_addr),
        .x_addr       (x_addr),
        .rd_en        (rd_en),
        .row_first    (row_first),
        .row_last     (row_last),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data),
        .result_taken (result_taken)
    );

endmodule

/* sim/matvec_assert.sv */
`timescale 1ns/1ps

module matvec_assert (
    input logic             clk,
    input logic             reset,
    input logic             input_ready,
    input logic             output_valid,
    input logic             output_ready,
    input matvec_pkg::acc_t output_data
);

    int unsigned fail_count = 0;   // the testbench adds this to its own error count

    // a result that the consumer has not taken must not move
    property stall_holds_result;
        @(posedge clk) disable iff (reset)
            (output_valid && !output_ready) |=> (output_valid && $stable(output_data));
    endproperty

    // the design only accepts input once every row result has been taken
    property no_input_while_result;
        @(posedge clk) disable iff (reset)
            !(output_valid && input_ready);
    endproperty

    property reset_clears_valid;
        @(posedge clk) reset |=> !output_valid;
    endproperty

    stall_holds_result_a: assert property (stall_holds_result)
        else begin
            fail_count++;
            $error("output_data or output_valid changed while the output was stalled");
        end

    no_input_while_result_a: assert property (no_input_while_result)
        else begin
            fail_count++;
            $error("input_ready was high while a result was waiting");
        end

    reset_clears_valid_a: assert property (reset_clears_valid)
        else begin
            fail_count++;
            $error("output_valid was high in the cycle after reset");
        end

endmodule

bind matvec_top matvec_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .input_ready  (input_ready),
    .output_valid (output_valid),
    .output_ready (output_ready),
    .output_data  (output_data)
);

/* sim/matvec_tb.sv */
`timescale 1ns/1ps
`include "matvec_defs.svh"

module matvec_tb;

    localparam int N            = `MATVEC_N;
    localparam int JOB_COUNT    = 6;     // random jobs after the directed ones
    localparam int WORD_TIMEOUT = 50;
    localparam int ROW_TIMEOUT  = 400;
    localparam logic [31:0] SEED = 32'd24;

    localparam longint ACC_HI = (longint'(1) <<< (`MATVEC_ACC_W - 1)) - 1;
    localparam longint ACC_LO = -(longint'(1) <<< (`MATVEC_ACC_W - 1));
    localparam matvec_pkg::elem_t ELEM_MAX = {1'b0, {(`MATVEC_IN_W-1){1'b1}}};
    localparam matvec_pkg::elem_t ELEM_MIN = {1'b1, {(`MATVEC_IN_W-1){1'b0}}};

    logic              clk;
    logic              reset;
    logic              input_valid;
    logic              input_ready;
    matvec_pkg::elem_t input_data;
    logic              new_matrix;
    logic              output_valid;
    logic              output_ready;
    matvec_pkg::acc_t  output_data;

    matvec_pkg::elem_t job_w [N*N];      // words of the job being sent
    matvec_pkg::elem_t job_x [N];
    matvec_pkg::elem_t w_model [N*N];    // matrix the DUT should hold
    matvec_pkg::elem_t x_model [N];
    matvec_pkg::acc_t  expected [N];

    logic [31:0] rng_state = SEED;
    int value_errs = 0;
    int timeout_errs = 0;

    matvec_top DUT (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .input_data   (input_data),
        .new_matrix   (new_matrix),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_rand();
        return r[0];
    endfunction

    function automatic matvec_pkg::elem_t rand_elem();
        logic [31:0] r;
        r = next_rand();
        return matvec_pkg::elem_t'(r[`MATVEC_IN_W-1:0]);
    endfunction

    // sum in column order, clamping to the 28-bit range after every addition
    function automatic matvec_pkg::acc_t row_model(input int r);
        longint sum;
        longint p;
        sum = 0;
        for (int c = 0; c < N; c++) begin
            p = longint'(w_model[r*N + c]) * longint'(x_model[c]);
            sum = sum + p;
            if (sum > ACC_HI) begin
                sum = ACC_HI;
            end else if (sum < ACC_LO) begin
                sum = ACC_LO;
            end
        end
        return matvec_pkg::acc_t'(sum);
    endfunction

    task automatic check_acc(input string name, input matvec_pkg::acc_t got,
                             input matvec_pkg::acc_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // one clock with a fresh random output_ready
    task automatic tick();
        output_ready <= rand_bit();
        @(posedge clk);
    endtask

    task automatic send_word(input matvec_pkg::elem_t d, input logic nm);
        int gap;
        int waited;
        logic sent;
        if (timeout_errs != 0) return;
        gap = int'(next_rand() % 4);
        for (int i = 0; i < gap; i++) begin
            input_valid <= 1'b0;
            tick();
        end
        input_valid <= 1'b1;
        input_data  <= d;
        new_matrix  <= nm;
        sent = 1'b0;
        waited = 0;
        while (!sent && waited < WORD_TIMEOUT) begin
            tick();
            waited++;
            sent = input_ready;   // valid was already high at this edge
        end
        if (!sent) begin
            timeout_errs++;
            $display("an input word was not accepted within %0d cycles", WORD_TIMEOUT);
        end
    endtask

    task automatic collect_row(input int r);
        int waited;
        logic taken;
        if (timeout_errs != 0) return;
        taken = 1'b0;
        waited = 0;
        while (!taken && waited < ROW_TIMEOUT) begin
            tick();
            waited++;
            check_level("input_ready", input_ready, 1'b0);   // no input during compute
            if (output_valid && output_ready) begin
                taken = 1'b1;
                check_acc("output_data", output_data, expected[r]);
            end
        end
        if (!taken) begin
            timeout_errs++;
            $display("the result of row %0d did not arrive within %0d cycles", r, ROW_TIMEOUT);
        end
    endtask

    task automatic run_job(input logic nm);
        if (timeout_errs != 0) return;
        if (nm) begin
            for (int i = 0; i < N*N; i++) w_model[i] = job_w[i];
        end
        for (int c = 0; c < N; c++) x_model[c] = job_x[c];
        for (int r = 0; r < N; r++) expected[r] = row_model(r);

        // only the first word carries the job's new_matrix, later levels are noise
        if (nm) begin
            for (int i = 0; i < N*N; i++) send_word(job_w[i], (i == 0) ? 1'b1 : rand_bit());
        end
        for (int c = 0; c < N; c++) send_word(job_x[c], (!nm && c == 0) ? 1'b0 : rand_bit());
        input_valid <= 1'b0;

        for (int r = 0; r < N; r++) collect_row(r);
        if (timeout_errs == 0) begin
            tick();
            check_level("input_ready", input_ready, 1'b1);
            check_level("output_valid", output_valid, 1'b0);   // exactly 8 results
        end
    endtask

    task automatic fill_random(input logic nm);
        if (nm) begin
            for (int i = 0; i < N*N; i++) job_w[i] = rand_elem();
        end
        for (int c = 0; c < N; c++) job_x[c] = rand_elem();
    endtask

    task automatic fill_const(input matvec_pkg::elem_t wv, input matvec_pkg::elem_t xv);
        for (int i = 0; i < N*N; i++) job_w[i] = wv;
        for (int c = 0; c < N; c++) job_x[c] = xv;
    endtask

    initial begin
        logic nm;
        reset        = 1'b1;
        input_valid  = 1'b0;
        input_data   = '0;
        new_matrix   = 1'b0;
        output_ready = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_level("output_valid", output_valid, 1'b0);
        check_level("input_ready", input_ready, 1'b1);

        fill_random(1'b1);
        run_job(1'b1);
        fill_random(1'b0);   // new vector against the stored matrix
        run_job(1'b0);

        for (int j = 0; j < JOB_COUNT; j++) begin
            nm = rand_bit();
            fill_random(nm);
            run_job(nm);
        end

        fill_const(ELEM_MAX, ELEM_MAX);   // every row clamps high
        run_job(1'b1);
        fill_const(ELEM_MIN, ELEM_MAX);   // every row clamps low
        run_job(1'b1);

        // row r starts with r positive products, so rows clamp high and then fall back
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) job_w[r*N + c] = (c < r) ? ELEM_MAX : ELEM_MIN;
        end
        for (int c = 0; c < N; c++) job_x[c] = ELEM_MAX;
        run_job(1'b1);
        fill_random(1'b0);
        run_job(1'b0);

        $display("results: %0d value errors, %0d timeouts, %0d assertion failures",
                 value_errs, timeout_errs, DUT.u_assert.fail_count);
        if (value_errs == 0 && timeout_errs == 0 && DUT.u_assert.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+design
design/matvec_pkg.sv
design/coeff_memory.sv
design/pipe_multiplier.sv
design/mac_datapath.sv
design/matvec_control.sv
design/matvec_top.sv
sim/matvec_assert.sv
sim/matvec_tb.sv

/* Makefile */
TOP = matvec_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
